// File: hdl/drs_cfg_regs.sv
`timescale 1ns/100ps

module drs_cfg_regs import drs_pkg::*; (
  input  logic     clock_i,
  input  logic     reset_i,
  input  logic     freeze_i,
  input  drs_ctl_t ctl_i,
  output drs_cfg_t cfg_o
);

  // ----------------------------------------------------------
  // settings follow the host until an event starts
  // ----------------------------------------------------------

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      cfg_o <= '0;
    end else if (!freeze_i) begin
      cfg_o.dmode            <= ctl_i.dmode;
      cfg_o.adc_latency      <= ctl_i.adc_latency;
      cfg_o.wait_vdd_clocks  <= ctl_i.wait_vdd_clocks;
      cfg_o.sample_count_max <= ctl_i.sample_count_max;
      // reserved config bits forced high
      cfg_o.config_byte      <= ctl_i.config_byte | CONFIG_RESERVED;
      cfg_o.chn_config       <= ctl_i.chn_config;
      // channel 8 rides along with any enabled channel
      cfg_o.readout_mask     <= {|ctl_i.readout_mask, ctl_i.readout_mask};
    end
  end

endmodule

// File: hdl/drs_chan_sequencer.sv
`timescale 1ns/100ps

module drs_chan_sequencer import drs_pkg::*; (
  input  logic                    clock_i,
  input  logic                    reset_i,
  input  logic                    event_start_i,
  input  logic                    chan_done_i,
  input  logic [NUM_CHANNELS-1:0] mask_i,
  output chan_t                   chan_o,
  output logic                    first_o,
  output logic                    last_o
);

  // channels of this event still to be read
  logic [NUM_CHANNELS-1:0] pending_q;
  logic [NUM_CHANNELS-1:0] remaining;

  // ----------------------------------------------------------
  // pending set and first channel flag
  // ----------------------------------------------------------

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      pending_q <= '0;
      first_o   <= 1'b0;
    end else if (event_start_i) begin
      pending_q <= mask_i;
      first_o   <= 1'b1;
    end else if (chan_done_i) begin
      // retire the channel just read
      pending_q <= remaining;
      first_o   <= 1'b0;
    end
  end

  // ----------------------------------------------------------
  // lowest pending channel
  // ----------------------------------------------------------

  // priority search, lowest index wins
  always_comb begin
    chan_o = '0;
    for (int i = NUM_CHANNELS - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        chan_o = chan_t'(i);
      end
    end
  end

  assign remaining = pending_q & ~(NUM_CHANNELS'(1) << chan_o);
  // nothing left beyond the current one
  assign last_o    = ~|remaining;

endmodule

// File: hdl/drs_fsm.sv
`timescale 1ns/100ps

module drs_fsm import drs_pkg::*; #(
  parameter int START_WAIT_CLOCKS = 105
) (
  input  logic       clock_i,
  input  logic       reset_i,
  input  drs_cmd_t   cmd_i,
  input  logic       trigger_i,
  input  drs_cfg_t   cfg_i,
  // serial loader
  output logic       load_o,
  output logic [7:0] word_o,
  input  logic       srclk_en_i,
  input  logic       srin_i,
  input  logic       done_i,
  // channel sequencer
  output logic       event_start_o,
  output logic       chan_done_o,
  input  chan_t      chan_i,
  input  logic       last_i,
  // readout engine
  output logic       chan_start_o,
  input  logic       chan_end_i,
  input  logic       ro_srclk_en_i,
  // status and chip
  output logic       freeze_o,
  output drs_pins_t  pins_o,
  output logic       readout_complete_o,
  output logic       busy_o
);

  drs_state_t  state_q;
  drs_state_t  state_d;
  logic [15:0] timer_q;
  logic        reinit_q;
  logic        reinit_req;
  logic [3:0]  addr_d;
  logic        srclk_d;
  logic        srin_d;

  // reinit pulse held until INIT is reached
  assign reinit_req = reinit_q || cmd_i.reinit;

  // ----------------------------------------------------------
  // next state
  // ----------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      // two cycles of chip reset
      INIT: if (timer_q == 16'd1) state_d = IDLE;
      IDLE: begin
        if (reinit_req) state_d = INIT;
        else if (cmd_i.configure) state_d = CONF_WORD;
        else if (cmd_i.start) state_d = START_RUNNING;
      end
      // reinit stays pending across the configure words
      CONF_WORD: if (done_i) state_d = WSR_WORD;
      WSR_WORD: if (done_i) state_d = IDLE;
      // let the domino wave run before arming
      START_RUNNING: begin
        if (reinit_req) state_d = INIT;
        else if (timer_q == 16'(START_WAIT_CLOCKS)) state_d = RUNNING;
      end
      RUNNING: begin
        if (reinit_req) state_d = INIT;
        else if (|cfg_i.readout_mask && (trigger_i || !cfg_i.dmode)) state_d = TRIGGER;
      end
      TRIGGER: state_d = reinit_req ? INIT : WAIT_VDD;
      // supply settle
      WAIT_VDD: begin
        if (reinit_req) state_d = INIT;
        else if (timer_q == cfg_i.wait_vdd_clocks) state_d = RSR_LOAD;
      end
      RSR_LOAD: state_d = reinit_req ? INIT : ADC_READOUT;
      // channel readout runs to the end, reinit taken in DONE
      ADC_READOUT: if (chan_end_i && last_i) state_d = STOP_CELL;
      STOP_CELL: state_d = DONE;
      DONE: state_d = reinit_req ? INIT : IDLE;
      default: state_d = INIT;
    endcase
  end

  // ----------------------------------------------------------
  // state, timer, reinit and busy
  // ----------------------------------------------------------

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_q  <= INIT;
      timer_q  <= '0;
      reinit_q <= 1'b0;
      busy_o   <= 1'b0;
    end else begin
      state_q  <= state_d;
      // one timer, restarted on every state change
      timer_q  <= (state_d != state_q) ? '0 : timer_q + 16'd1;
      reinit_q <= (state_q != INIT) && reinit_req;
      busy_o   <= state_d inside {START_RUNNING, RUNNING, TRIGGER, WAIT_VDD,
                                  RSR_LOAD, ADC_READOUT, STOP_CELL};
    end
  end

  // ----------------------------------------------------------
  // handshakes
  // ----------------------------------------------------------

  assign load_o = (state_q == IDLE && !reinit_req && cmd_i.configure) ||
                  (state_q == CONF_WORD && done_i);
  // config word first, channel pattern on the reload
  assign word_o = (state_q == IDLE) ? cfg_i.config_byte : cfg_i.chn_config;

  assign event_start_o = (state_q == TRIGGER);
  assign chan_done_o   = (state_q == ADC_READOUT) && chan_end_i;
  assign chan_start_o  = (state_q == RSR_LOAD && !reinit_req) ||
                         (state_q == ADC_READOUT && chan_end_i && !last_i);

  assign freeze_o = state_q inside {TRIGGER, WAIT_VDD, RSR_LOAD, ADC_READOUT,
                                    STOP_CELL, DONE};
  assign readout_complete_o = (state_q == DONE);

  // ----------------------------------------------------------
  // chip pins
  // ----------------------------------------------------------

  // one strobe source per state
  always_comb begin
    addr_d  = ADR_IDLE;
    srclk_d = 1'b0;
    srin_d  = 1'b0;
    case (state_q)
      CONF_WORD: begin
        addr_d  = ADR_CONFIG;
        srclk_d = srclk_en_i;
        srin_d  = srin_i;
      end
      WSR_WORD: begin
        addr_d  = ADR_WRITE_SR;
        srclk_d = srclk_en_i;
        srin_d  = srin_i;
      end
      // channel address set up ahead of rsrload
      WAIT_VDD, RSR_LOAD: addr_d = chan_i;
      ADC_READOUT: begin
        addr_d  = chan_i;
        srclk_d = ro_srclk_en_i;
      end
      default: addr_d = ADR_IDLE;
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      pins_o <= '{addr: ADR_IDLE, default: 1'b0};
    end else begin
      pins_o.addr     <= addr_d;
      pins_o.nreset   <= (state_q != INIT);
      pins_o.rsrload  <= (state_q == RSR_LOAD);
      pins_o.srclk_en <= srclk_d;
      pins_o.srin     <= srin_d;
      // denable and dwrite hold their level between states
      case (state_q)
        INIT: begin
          pins_o.denable <= 1'b0;
          pins_o.dwrite  <= 1'b0;
        end
        START_RUNNING: begin
          pins_o.denable <= 1'b1;
          pins_o.dwrite  <= 1'b1;
        end
        // stop sampling for readout
        TRIGGER: pins_o.dwrite <= 1'b0;
        // keep the chip warm between events
        DONE: pins_o.dwrite <= 1'b1;
        default: pins_o.dwrite <= pins_o.dwrite;
      endcase
    end
  end

endmodule

// File: hdl/drs_pkg.sv
package drs_pkg;

  // ----------------------------------------------------------
  // chip addresses, from the DRS4 datasheet
  // ----------------------------------------------------------

  localparam logic [3:0] ADR_READ_SR  = 4'b1011;
  localparam logic [3:0] ADR_WRITE_SR = 4'b1101;
  localparam logic [3:0] ADR_CONFIG   = 4'b1100;
  // read shift register is parked on the bus between events
  localparam logic [3:0] ADR_IDLE     = ADR_READ_SR;

  // eight signal channels plus the reference channel 8
  localparam int NUM_CHANNELS = 9;

  // config bits 3..7 are reserved and must always be written as 1
  localparam logic [7:0] CONFIG_RESERVED = 8'hf8;

  typedef logic [3:0] chan_t;

  typedef enum logic [3:0] {
    INIT, IDLE, CONF_WORD, WSR_WORD, START_RUNNING, RUNNING,
    TRIGGER, WAIT_VDD, RSR_LOAD, ADC_READOUT, STOP_CELL, DONE
  } drs_state_t;

  // ----------------------------------------------------------
  // command pulses and settings
  // ----------------------------------------------------------

  typedef struct packed {
    logic start;
    logic reinit;
    logic configure;
  } drs_cmd_t;

  // raw settings as driven by the host
  typedef struct packed {
    logic        reserved;
    logic        dmode;             // 1 continuous domino, 0 single shot
    logic [5:0]  adc_latency;       // srclk start to first valid adc word
    logic [15:0] wait_vdd_clocks;
    logic [9:0]  sample_count_max;  // samples per channel minus one
    logic [7:0]  config_byte;       // dmode, pllen, wsrloop, reserved
    logic [7:0]  chn_config;        // write shift register pattern
    logic [7:0]  readout_mask;
  } drs_ctl_t;

  // settings as frozen for one event
  typedef struct packed {
    logic        dmode;
    logic [5:0]  adc_latency;
    logic [15:0] wait_vdd_clocks;
    logic [9:0]  sample_count_max;
    logic [7:0]  config_byte;
    logic [7:0]  chn_config;
    logic [NUM_CHANNELS-1:0] readout_mask;
  } drs_cfg_t;

  // chip control pins
  typedef struct packed {
    logic [3:0] addr;
    logic       nreset;
    logic       denable;
    logic       dwrite;
    logic       rsrload;
    logic       srclk_en;
    logic       srin;
  } drs_pins_t;

endpackage

// File: hdl/drs_readout.sv
`timescale 1ns/100ps

module drs_readout import drs_pkg::*; #(
  parameter int ADC_WIDTH = 14
) (
  input  logic                 clock_i,
  input  logic                 reset_i,
  input  logic                 chan_start_i,
  input  logic                 first_chan_i,
  input  drs_cfg_t             cfg_i,
  input  logic [ADC_WIDTH-1:0] adc_data_i,
  input  logic                 srout_i,
  output logic                 srclk_en_o,
  output logic [9:0]           stop_cell_o,
  output logic [ADC_WIDTH-1:0] fifo_wdata_o,
  output logic                 fifo_wen_o,
  output logic                 chan_end_o
);

  logic [ADC_WIDTH-1:0] adc_q;
  logic                 active_q;
  logic                 srclk_q;
  logic [10:0]          rd_cnt_q;
  logic [9:0]           word_cnt_q;
  logic [3:0]           sc_bits_q;
  logic [9:0]           stop_sr_q;
  logic                 write_en;

  // adc sampled once on the rising edge
  always_ff @(posedge clock_i) begin
    adc_q <= adc_data_i;
  end

  // ----------------------------------------------------------
  // clock counting and fifo writes
  // ----------------------------------------------------------

  // sample_count_max+1 readout clocks per channel
  assign srclk_en_o = active_q && (rd_cnt_q <= {1'b0, cfg_i.sample_count_max});
  // adc pipeline delay before words are valid
  assign write_en   = active_q && (rd_cnt_q >= {5'b0, cfg_i.adc_latency});

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      active_q    <= 1'b0;
      rd_cnt_q    <= '0;
      word_cnt_q  <= '0;
      srclk_q     <= 1'b0;
      fifo_wen_o  <= 1'b0;
      chan_end_o  <= 1'b0;
      sc_bits_q   <= '0;
      stop_cell_o <= '0;
    end else begin
      srclk_q    <= srclk_en_o;
      fifo_wen_o <= write_en;
      chan_end_o <= write_en && (word_cnt_q == cfg_i.sample_count_max);
      if (chan_start_i) begin
        active_q   <= 1'b1;
        rd_cnt_q   <= '0;
        word_cnt_q <= '0;
      end else if (active_q) begin
        rd_cnt_q <= rd_cnt_q + 11'd1;
        if (write_en) begin
          word_cnt_q <= word_cnt_q + 10'd1;
          // last word of the channel
          if (word_cnt_q == cfg_i.sample_count_max) begin
            active_q <= 1'b0;
          end
        end
      end
      // stop cell bit count, first channel only
      if (chan_start_i && first_chan_i) begin
        sc_bits_q <= '0;
      end else if (first_chan_i && srclk_q && (sc_bits_q < 4'd10)) begin
        sc_bits_q <= sc_bits_q + 4'd1;
      end
      // no follow-on channel, so the fsm enters STOP_CELL next
      if (chan_end_o && !chan_start_i) begin
        stop_cell_o <= stop_sr_q;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (write_en) begin
      fifo_wdata_o <= adc_q;
    end
  end

  // ----------------------------------------------------------
  // stop cell capture
  // ----------------------------------------------------------

  // chip gives msb on rsrload, then one bit per readout clock
  always_ff @(posedge clock_i) begin
    if (first_chan_i && srclk_q && (sc_bits_q < 4'd10)) begin
      stop_sr_q <= {stop_sr_q[8:0], srout_i};
    end
  end

endmodule

// File: hdl/drs_serial_loader.sv
`timescale 1ns/100ps

module drs_serial_loader (
  input  logic       clock_i,
  input  logic       reset_i,
  input  logic       load_i,
  input  logic [7:0] word_i,
  output logic       srclk_en_o,
  output logic       srin_o,
  output logic       done_o
);

  logic [7:0] shift_q;
  logic [2:0] bit_cnt_q;
  logic       active_q;

  // ----------------------------------------------------------
  // bit counter
  // ----------------------------------------------------------

  // a load during the final bit restarts cleanly for back to back words
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      active_q  <= 1'b0;
      bit_cnt_q <= '0;
    end else if (load_i) begin
      active_q  <= 1'b1;
      bit_cnt_q <= '0;
    end else if (active_q) begin
      bit_cnt_q <= bit_cnt_q + 3'd1;
      if (bit_cnt_q == 3'd7) begin
        active_q <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // data shifter
  // ----------------------------------------------------------

  // msb first, one bit per strobe
  always_ff @(posedge clock_i) begin
    if (load_i) begin
      shift_q <= word_i;
    end else if (active_q) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  assign srclk_en_o = active_q;
  assign srin_o     = shift_q[7];
  // flagged in the cycle of the eighth strobe
  assign done_o     = active_q && (bit_cnt_q == 3'd7);

endmodule

// File: hdl/drs_top.sv
`timescale 1ns/100ps

module drs_top import drs_pkg::*; #(
  parameter int ADC_WIDTH         = 14,
  parameter int START_WAIT_CLOCKS = 105
) (
  input  logic                 clock,
  input  logic                 reset,
  input  drs_cmd_t             cmd_i,
  input  drs_ctl_t             ctl_i,
  input  logic                 trigger_i,
  input  logic [ADC_WIDTH-1:0] adc_data_i,
  input  logic                 drs_srout_i,
  output drs_pins_t            drs_pins_o,
  output logic [9:0]           drs_stop_cell_o,
  output logic [ADC_WIDTH-1:0] fifo_wdata_o,
  output logic                 fifo_wen_o,
  output logic                 readout_complete_o,
  output logic                 busy_o
);

  drs_cfg_t   cfg;
  logic       freeze;
  // loader
  logic       load;
  logic [7:0] word;
  logic       ld_srclk_en;
  logic       ld_srin;
  logic       ld_done;
  // sequencer
  logic       event_start;
  logic       chan_done;
  chan_t      chan;
  logic       first_chan;
  logic       last_chan;
  // readout
  logic       chan_start;
  logic       chan_end;
  logic       ro_srclk_en;

  // ----------------------------------------------------------
  // instances
  // ----------------------------------------------------------

  drs_cfg_regs u_cfg_regs (
    .clock_i  (clock),
    .reset_i  (reset),
    .freeze_i (freeze),
    .ctl_i    (ctl_i),
    .cfg_o    (cfg)
  );

  drs_serial_loader u_loader (
    .clock_i    (clock),
    .reset_i    (reset),
    .load_i     (load),
    .word_i     (word),
    .srclk_en_o (ld_srclk_en),
    .srin_o     (ld_srin),
    .done_o     (ld_done)
  );

  drs_chan_sequencer u_chan_seq (
    .clock_i       (clock),
    .reset_i       (reset),
    .event_start_i (event_start),
    .chan_done_i   (chan_done),
    .mask_i        (cfg.readout_mask),
    .chan_o        (chan),
    .first_o       (first_chan),
    .last_o        (last_chan)
  );

  drs_readout #(
    .ADC_WIDTH (ADC_WIDTH)
  ) u_readout (
    .clock_i      (clock),
    .reset_i      (reset),
    .chan_start_i (chan_start),
    .first_chan_i (first_chan),
    .cfg_i        (cfg),
    .adc_data_i   (adc_data_i),
    .srout_i      (drs_srout_i),
    .srclk_en_o   (ro_srclk_en),
    .stop_cell_o  (drs_stop_cell_o),
    .fifo_wdata_o (fifo_wdata_o),
    .fifo_wen_o   (fifo_wen_o),
    .chan_end_o   (chan_end)
  );

  drs_fsm #(
    .START_WAIT_CLOCKS (START_WAIT_CLOCKS)
  ) u_fsm (
    .clock_i            (clock),
    .reset_i            (reset),
    .cmd_i              (cmd_i),
    .trigger_i          (trigger_i),
    .cfg_i              (cfg),
    .load_o             (load),
    .word_o             (word),
    .srclk_en_i         (ld_srclk_en),
    .srin_i             (ld_srin),
    .done_i             (ld_done),
    .event_start_o      (event_start),
    .chan_done_o        (chan_done),
    .chan_i             (chan),
    .last_i             (last_chan),
    .chan_start_o       (chan_start),
    .chan_end_i         (chan_end),
    .ro_srclk_en_i      (ro_srclk_en),
    .freeze_o           (freeze),
    .pins_o             (drs_pins_o),
    .readout_complete_o (readout_complete_o),
    .busy_o             (busy_o)
  );

endmodule

// File: tb.f
hdl/drs_pkg.sv
hdl/drs_cfg_regs.sv
hdl/drs_serial_loader.sv
hdl/drs_chan_sequencer.sv
hdl/drs_readout.sv
hdl/drs_fsm.sv
hdl/drs_top.sv
testbench/drs_chk.sv
testbench/tb_drs.sv

// File: testbench/drs_chk.sv
`timescale 1ns/100ps

module drs_chk (
  input logic clock_i,
  input logic reset_i,
  input logic fifo_wen_i,
  input logic busy_i,
  input logic readout_complete_i,
  input logic rsrload_i
);

  // read back by the testbench at the end
  int fail_count = 0;

  // ----------------------------------------------------------
  // protocol rules
  // ----------------------------------------------------------

  // fifo writes only inside an event
  wen_in_busy: assert property (@(posedge clock_i) disable iff (reset_i)
    fifo_wen_i |-> busy_i)
    else begin
      $error("fifo write while controller not busy");
      fail_count++;
    end

  complete_single: assert property (@(posedge clock_i) disable iff (reset_i)
    readout_complete_i |=> !readout_complete_i)
    else begin
      $error("readout_complete_o held longer than one cycle");
      fail_count++;
    end

  // one load per event
  rsrload_single: assert property (@(posedge clock_i) disable iff (reset_i)
    rsrload_i |=> !rsrload_i)
    else begin
      $error("rsrload held longer than one cycle");
      fail_count++;
    end

endmodule

bind drs_top drs_chk u_chk (
  .clock_i            (clock),
  .reset_i            (reset),
  .fifo_wen_i         (fifo_wen_o),
  .busy_i             (busy_o),
  .readout_complete_i (readout_complete_o),
  .rsrload_i          (drs_pins_o.rsrload)
);

// File: testbench/tb_drs.sv
`timescale 1ns/100ps

module tb_drs import drs_pkg::*; ();

  localparam int ADC_WIDTH  = 14;
  // short arming delay keeps the run brief
  localparam int START_WAIT = 20;
  localparam int NUM_ROWS   = 5;

  localparam int FLAG_BUSY     = 0;
  localparam int FLAG_NRESET   = 1;
  localparam int FLAG_COMPLETE = 2;

  localparam drs_cmd_t CMD_START     = '{start: 1'b1, default: 1'b0};
  localparam drs_cmd_t CMD_REINIT    = '{reinit: 1'b1, default: 1'b0};
  localparam drs_cmd_t CMD_CONFIGURE = '{configure: 1'b1, default: 1'b0};

  // one event per row
  typedef struct packed {
    logic [7:0] mask;
    logic [9:0] samples_max;
    logic [5:0] latency;
    logic       dmode;
    logic [9:0] stop_cell;
    logic       trigger;
  } row_t;

  logic                 clock = 1'b0;
  logic                 reset;
  drs_cmd_t             cmd;
  drs_ctl_t             ctl;
  logic                 trigger;
  logic [ADC_WIDTH-1:0] adc_data;
  logic                 srout;
  drs_pins_t            pins;
  logic [9:0]           stop_cell;
  logic [ADC_WIDTH-1:0] fifo_wdata;
  logic                 fifo_wen;
  logic                 readout_complete;
  logic                 busy;

  row_t        rows [NUM_ROWS];
  logic [31:0] lfsr_state;
  logic [9:0]  chip_sr;
  logic [9:0]  model_stop_cell;
  logic        rsr_seen;
  logic        srclk_seen;
  logic        rsr_prev;
  logic        capture_cfg;
  // fifo word seen while the chip was still sampling
  logic        dwrite_bad;
  // {addr, srin} per strobe
  logic [4:0]  cfg_bits [$];
  // channel tag of every fifo word
  logic [3:0]  tags [$];
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          errors_at_start;

  drs_top #(
    .ADC_WIDTH         (ADC_WIDTH),
    .START_WAIT_CLOCKS (START_WAIT)
  ) UUT (
    .clock              (clock),
    .reset              (reset),
    .cmd_i              (cmd),
    .ctl_i              (ctl),
    .trigger_i          (trigger),
    .adc_data_i         (adc_data),
    .drs_srout_i        (srout),
    .drs_pins_o         (pins),
    .drs_stop_cell_o    (stop_cell),
    .fifo_wdata_o       (fifo_wdata),
    .fifo_wen_o         (fifo_wen),
    .readout_complete_o (readout_complete),
    .busy_o             (busy)
  );

  always #2 clock = ~clock;

  // galois lfsr stepped once per bit taken
  function automatic logic [9:0] random_bits(input int count);
    logic [9:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[8:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return value;
  endfunction

  // ----------------------------------------------------------
  // chip and adc model
  // ----------------------------------------------------------

  always @(negedge clock) begin
    rsr_seen   <= pins.rsrload;
    srclk_seen <= pins.srclk_en;
    if (capture_cfg && pins.srclk_en) begin
      cfg_bits.push_back({pins.addr, pins.srin});
    end
    if (fifo_wen) begin
      tags.push_back(fifo_wdata[ADC_WIDTH-1 -: 4]);
      if (pins.dwrite || !pins.denable) begin
        dwrite_bad = 1'b1;
      end
    end
  end

  // adc word tagged with the address on the bus
  always @(posedge clock) begin
    #1;
    adc_data = {pins.addr, random_bits(ADC_WIDTH - 4)};
    // stop cell msb appears on rsrload and shifts once per strobe
    if (rsr_seen && !rsr_prev) begin
      chip_sr = model_stop_cell;
    end else if (srclk_seen) begin
      chip_sr = {chip_sr[8:0], 1'b0};
    end
    rsr_prev = rsr_seen;
    srout    = chip_sr[9];
  end

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  function automatic logic flag_value(input int which);
    case (which)
      FLAG_BUSY:   return busy;
      FLAG_NRESET: return pins.nreset;
      default:     return readout_complete;
    endcase
  endfunction

  task automatic wait_flag(input int which, input logic level, input int limit,
                           input string what, output logic ok);
    int count;
    count = 0;
    ok    = 1'b0;
    while (!ok && count < limit) begin
      next_cycle();
      count++;
      ok = (flag_value(which) == level);
    end
    if (!ok) begin
      $display("timeout after %0d cycles waiting for %s", limit, what);
      errors++;
    end
  endtask

  task automatic pulse_cmd(input drs_cmd_t c);
    cmd = c;
    next_cycle();
    cmd = '0;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
    errors_at_start = errors;
  endtask

  // ----------------------------------------------------------
  // tests
  // ----------------------------------------------------------

  task automatic check_reset();
    logic ok;
    if (pins.denable || pins.srclk_en || fifo_wen || busy) begin
      $display("ERR %0t: outputs active after reset, denable %b srclk_en %b wen %b busy %b",
               $time, pins.denable, pins.srclk_en, fifo_wen, busy);
      errors++;
    end
    wait_flag(FLAG_NRESET, 1'b1, 10, "nreset high after reset", ok);
    finish_test("reset");
  endtask

  task automatic check_configure();
    int         count;
    logic [7:0] conf_word;
    logic [7:0] wsr_word;
    logic       addr_bad;
    cfg_bits.delete();
    capture_cfg = 1'b1;
    pulse_cmd(CMD_CONFIGURE);
    count = 0;
    while (cfg_bits.size() < 16 && count < 60) begin
      next_cycle();
      count++;
    end
    // a few more cycles to catch stray strobes
    repeat (4) next_cycle();
    capture_cfg = 1'b0;
    if (cfg_bits.size() < 16) begin
      $display("timeout: only %0d of 16 configuration bits seen", cfg_bits.size());
      errors++;
    end else if (cfg_bits.size() != 16) begin
      $display("ERR %0t: %0d configuration strobes, expected 16", $time, cfg_bits.size());
      errors++;
    end else begin
      addr_bad = 1'b0;
      // msb arrives first
      for (int i = 0; i < 8; i++) begin
        conf_word = {conf_word[6:0], cfg_bits[i][0]};
        wsr_word  = {wsr_word[6:0], cfg_bits[i+8][0]};
        if (cfg_bits[i][4:1] != ADR_CONFIG || cfg_bits[i+8][4:1] != ADR_WRITE_SR) begin
          addr_bad = 1'b1;
        end
      end
      if (addr_bad) begin
        $display("ERR %0t: configuration bits sent at the wrong address", $time);
        errors++;
      end
      if (conf_word != (ctl.config_byte | 8'hf8)) begin
        $display("ERR %0t: config word %h, expected %h", $time, conf_word,
                 ctl.config_byte | 8'hf8);
        errors++;
      end
      if (wsr_word != ctl.chn_config) begin
        $display("ERR %0t: wsr word %h, expected %h", $time, wsr_word, ctl.chn_config);
        errors++;
      end
    end
    finish_test("configure");
  endtask

  task automatic run_row(input int r);
    row_t       row;
    logic       ok;
    logic       quiet;
    logic [3:0] expected [$];
    row = rows[r];
    ctl.readout_mask     = row.mask;
    ctl.sample_count_max = row.samples_max;
    ctl.adc_latency      = row.latency;
    ctl.dmode            = row.dmode;
    model_stop_cell      = row.stop_cell;
    // new ctl values register while idle
    next_cycle();
    next_cycle();
    tags.delete();
    dwrite_bad = 1'b0;
    pulse_cmd(CMD_START);
    wait_flag(FLAG_BUSY, 1'b1, 4, "busy_o after start", ok);
    if (row.trigger) begin
      next_cycle();
      trigger = 1'b1;
    end
    if (row.mask != 8'h00) begin
      wait_flag(FLAG_COMPLETE, 1'b1, 1500, "readout_complete_o", ok);
      trigger = 1'b0;
      if (ok) begin
        if (stop_cell != row.stop_cell) begin
          $display("ERR %0t: stop cell %h, expected %h", $time, stop_cell, row.stop_cell);
          errors++;
        end
        if (busy) begin
          $display("ERR %0t: busy_o still high with readout_complete_o", $time);
          errors++;
        end
        if (dwrite_bad) begin
          $display("ERR %0t: fifo written while dwrite high or denable low", $time);
          errors++;
        end
        // ascending channels with the reference channel last
        for (int ch = 0; ch < 8; ch++) begin
          if (row.mask[ch]) begin
            repeat (row.samples_max + 1) expected.push_back(4'(ch));
          end
        end
        repeat (row.samples_max + 1) expected.push_back(4'd8);
        if (tags.size() != expected.size()) begin
          $display("ERR %0t: %0d fifo words, expected %0d", $time, tags.size(),
                   expected.size());
          errors++;
        end else begin
          for (int i = 0; i < tags.size(); i++) begin
            if (tags[i] != expected[i]) begin
              $display("ERR %0t: fifo word %0d from channel %0d, expected %0d", $time, i,
                       tags[i], expected[i]);
              errors++;
              break;
            end
          end
        end
      end
      wait_flag(FLAG_BUSY, 1'b0, 10, "busy_o low after readout", ok);
      // domino wave running again after the event
      if (!pins.dwrite || !pins.denable) begin
        $display("ERR %0t: dwrite %b denable %b after readout, expected both high",
                 $time, pins.dwrite, pins.denable);
        errors++;
      end
    end else begin
      // no event may start with an empty mask
      quiet = 1'b1;
      for (int i = 0; i < 300; i++) begin
        next_cycle();
        if (readout_complete || fifo_wen || pins.rsrload) begin
          quiet = 1'b0;
        end
      end
      if (!quiet || tags.size() != 0) begin
        $display("ERR %0t: readout started with an empty mask", $time);
        errors++;
      end
      trigger = 1'b0;
      pulse_cmd(CMD_REINIT);
      wait_flag(FLAG_NRESET, 1'b0, 4, "nreset low after reinit", ok);
      wait_flag(FLAG_NRESET, 1'b1, 10, "nreset high after reinit", ok);
    end
    finish_test($sformatf("row %0d", r));
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial begin
    reset                = 1'b1;
    cmd                  = '0;
    ctl                  = '0;
    ctl.config_byte      = 8'h05;
    ctl.chn_config       = 8'ha7;
    ctl.wait_vdd_clocks  = 16'd6;
    ctl.adc_latency      = 6'd2;
    ctl.sample_count_max = 10'd9;
    trigger              = 1'b0;
    adc_data             = '0;
    srout                = 1'b0;
    lfsr_state           = 32'h54d6_0d98;
    chip_sr              = '0;
    model_stop_cell      = '0;
    rsr_seen             = 1'b0;
    srclk_seen           = 1'b0;
    rsr_prev             = 1'b0;
    capture_cfg          = 1'b0;
    dwrite_bad           = 1'b0;
    errors               = 0;
    tests_run            = 0;
    tests_failed         = 0;
    errors_at_start      = 0;

    // mask, samples, latency, dmode, stop cell, trigger
    rows[0] = '{8'h05, 10'd9,  6'd2, 1'b1, 10'h2a5, 1'b1};
    rows[1] = '{8'h82, 10'd12, 6'd5, 1'b1, 10'h1c3, 1'b1};
    rows[2] = '{8'h00, 10'd9,  6'd3, 1'b1, 10'h000, 1'b1};
    rows[3] = '{8'h18, 10'd10, 6'd4, 1'b0, 10'h35a, 1'b0};
    rows[4] = '{8'hff, 10'd9,  6'd3, 1'b1, 10'h0f1, 1'b1};

    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;

    check_reset();
    check_configure();
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end

    if (UUT.u_chk.fail_count != 0) begin
      $display("%0d assertion failures in the checker", UUT.u_chk.fail_count);
      errors += UUT.u_chk.fail_count;
    end
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
